/* design/exec_cfg.svh */
// width settings of the execute stage, included by the package and by RTL that sizes logic
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data path width, operands and results are one word
`define EXEC_XLEN 32

// register file address width
`define EXEC_RADDR_W 5

`endif

/* design/exec_pkg.sv */
// shared types of the execute stage, compile before the interface and every RTL module
`include "exec_cfg.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]    word_t;     // operands, immediates, pcs, results
    typedef logic [`EXEC_RADDR_W-1:0] reg_addr_t; // destination register
    typedef logic [3:0]               op_code_t;  // raw opcode field, cast per unit

    // unit select, a zero class marks an invalid operation
    typedef enum logic [1:0] {
        CLS_NONE   = 2'd0,
        CLS_ALU    = 2'd1,
        CLS_BRANCH = 2'd2,
        CLS_MUL    = 2'd3
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_BEQ  = 4'd0,
        BR_BNE  = 4'd1,
        BR_BLT  = 4'd2,
        BR_BGE  = 4'd3,
        BR_BLTU = 4'd4,
        BR_BGEU = 4'd5,
        BR_JAL  = 4'd6,
        BR_JALR = 4'd7
    } br_op_e;

    typedef enum logic [3:0] {
        MUL_MUL    = 4'd0, // low word
        MUL_MULH   = 4'd1, // signed x signed, high word
        MUL_MULHSU = 4'd2, // signed x unsigned, high word
        MUL_MULHU  = 4'd3  // unsigned x unsigned, high word
    } mul_op_e;

endpackage

/* design/exec_issue_if.sv */
// one issued operation as seen by the execute stage, driven by the top and read by ctrl and units
`timescale 1ns/1ps

interface exec_issue_if;
    import exec_pkg::*;

    logic      valid;    // single cycle strobe
    op_class_e op_class;
    op_code_t  op_code;
    word_t     rs1_val;
    word_t     rs2_val;  // register or immediate, picked upstream
    word_t     imm;
    word_t     pc;
    reg_addr_t rd_addr;

    // decode side
    modport ctrl (
        input valid,
        input op_class,
        input op_code,
        input rd_addr
    );

    // datapath side
    modport unit (
        input op_code,
        input rs1_val,
        input rs2_val,
        input imm,
        input pc
    );

endinterface

/* design/exec_alu.sv */
// combinational RV32I integer ALU, evaluates the issued operands every cycle
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_alu (
    exec_issue_if.unit      issue,
    output exec_pkg::word_t result_o
);
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    alu_op_e            alu_op;
    word_t              op_a;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;

    assign alu_op = alu_op_e'(issue.op_code);
    assign op_a   = issue.rs1_val;
    assign op_b   = issue.rs2_val;
    assign shamt  = op_b[SHAMT_W-1:0]; // upper bits of the amount are ignored

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result_o = op_a + op_b;
            end
            ALU_SUB: begin
                result_o = op_a - op_b;
            end
            ALU_SLL: begin
                result_o = op_a << shamt;
            end
            ALU_SLT: begin
                result_o = word_t'($signed(op_a) < $signed(op_b));
            end
            ALU_SLTU: begin
                result_o = word_t'(op_a < op_b);
            end
            ALU_XOR: begin
                result_o = op_a ^ op_b;
            end
            ALU_SRL: begin
                result_o = op_a >> shamt;
            end
            ALU_SRA: begin
                result_o = word_t'($signed(op_a) >>> shamt); // sign fill
            end
            ALU_OR: begin
                result_o = op_a | op_b;
            end
            ALU_AND: begin
                result_o = op_a & op_b;
            end
            default: begin
                result_o = '0; // unused encodings
            end
        endcase
    end

endmodule

/* design/exec_branch.sv */
// combinational branch and jump unit, gives taken flag, target and link value
`timescale 1ns/1ps

module exec_branch (
    exec_issue_if.unit      issue,
    output logic            taken_o,
    output exec_pkg::word_t target_o,
    output exec_pkg::word_t link_o
);
    import exec_pkg::*;

    br_op_e br_op;
    logic   eq;
    logic   lt;         // signed compare
    logic   ltu;        // unsigned compare
    word_t  pc_target;
    word_t  jalr_sum;

    assign br_op = br_op_e'(issue.op_code);

    assign eq  = (issue.rs1_val == issue.rs2_val);
    assign lt  = ($signed(issue.rs1_val) < $signed(issue.rs2_val));
    assign ltu = (issue.rs1_val < issue.rs2_val);

    always_comb begin
        case (br_op)
            BR_BEQ: begin
                taken_o = eq;
            end
            BR_BNE: begin
                taken_o = !eq;
            end
            BR_BLT: begin
                taken_o = lt;
            end
            BR_BGE: begin
                taken_o = !lt;
            end
            BR_BLTU: begin
                taken_o = ltu;
            end
            BR_BGEU: begin
                taken_o = !ltu;
            end
            BR_JAL, BR_JALR: begin
                taken_o = 1'b1; // jumps always leave
            end
            default: begin
                taken_o = 1'b0;
            end
        endcase
    end

    assign pc_target = issue.pc + issue.imm;
    assign jalr_sum  = issue.rs1_val + issue.imm;

    // jalr drops bit 0 of the computed address
    assign target_o = (br_op == BR_JALR) ? (jalr_sum & ~word_t'(1)) : pc_target;

    assign link_o = issue.pc + word_t'(4); // return address

endmodule

/* design/exec_mul.sv */
// two-stage pipelined 32x32 multiplier, result valid two cycles after the start strobe
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_mul (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  exec_pkg::mul_op_e op_i,
    exec_issue_if.unit        issue,
    output exec_pkg::word_t   result_o
);
    import exec_pkg::*;

    localparam int XLEN = `EXEC_XLEN;

    logic                     a_sign;
    logic                     b_sign;
    logic signed [XLEN:0]     a_q;       // operands widened by one bit
    logic signed [XLEN:0]     b_q;
    mul_op_e                  op1_q;
    logic                     v1_q;      // stage one holds a new pair
    logic signed [2*XLEN+1:0] prod_full;
    logic [2*XLEN-1:0]        prod_q;
    mul_op_e                  op2_q;

    // only the high variants care about operand sign
    assign a_sign = (op_i == MUL_MULH) || (op_i == MUL_MULHSU);
    assign b_sign = (op_i == MUL_MULH);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            v1_q <= 1'b0;
        end else begin
            v1_q <= start_i;
        end
    end

    // stage one, extended operands and opcode
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q   <= {a_sign & issue.rs1_val[XLEN-1], issue.rs1_val};
            b_q   <= {b_sign & issue.rs2_val[XLEN-1], issue.rs2_val};
            op1_q <= op_i;
        end
    end

    assign prod_full = a_q * b_q; // 33x33 signed covers all four variants

    // stage two, full product
    always_ff @(posedge clk_i) begin
        if (v1_q) begin
            prod_q <= prod_full[2*XLEN-1:0];
            op2_q  <= op1_q;
        end
    end

    assign result_o = (op2_q == MUL_MUL) ? prod_q[XLEN-1:0] : prod_q[2*XLEN-1:XLEN];

endmodule

/* design/exec_ctrl.sv */
// execute control, decodes each issue, aligns unit results to three cycles and drives write-back
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    exec_issue_if.ctrl          issue,
    input  exec_pkg::word_t     alu_result_i,
    input  logic                br_taken_i,
    input  exec_pkg::word_t     br_target_i,
    input  exec_pkg::word_t     br_link_i,
    input  exec_pkg::word_t     mul_result_i,
    output logic                mul_start_o,
    output exec_pkg::mul_op_e   mul_op_o,
    output logic                wb_valid_o,
    output exec_pkg::reg_addr_t wb_addr_o,
    output exec_pkg::word_t     wb_data_o,
    output logic                redirect_o,
    output exec_pkg::word_t     redirect_pc_o
);
    import exec_pkg::*;

    br_op_e    br_op;
    logic      is_jump;
    logic      dec_wr;     // write intent of the issued op
    logic      dec_redir;
    word_t     dec_data;   // early result, alu or link

    op_class_e s1_cls;
    op_class_e s2_cls;
    reg_addr_t s1_rd;
    reg_addr_t s2_rd;
    logic      s1_wr;
    logic      s2_wr;
    logic      s1_redir;
    logic      s2_redir;
    word_t     s1_data;
    word_t     s2_data;
    word_t     s1_target;
    word_t     s2_target;

    assign br_op   = br_op_e'(issue.op_code);
    assign is_jump = (br_op == BR_JAL) || (br_op == BR_JALR);

    assign mul_start_o = issue.valid && (issue.op_class == CLS_MUL);
    assign mul_op_o    = mul_op_e'(issue.op_code);

    always_comb begin
        dec_wr    = 1'b0;
        dec_redir = 1'b0;
        dec_data  = alu_result_i;
        if (issue.valid) begin
            case (issue.op_class)
                CLS_ALU, CLS_MUL: begin
                    dec_wr = 1'b1;
                end
                CLS_BRANCH: begin
                    dec_wr    = is_jump;    // only jumps write the link
                    dec_redir = br_taken_i;
                    dec_data  = br_link_i;
                end
                default: begin
                    dec_wr = 1'b0;          // CLS_NONE does nothing
                end
            endcase
        end
        if (issue.rd_addr == '0) begin
            dec_wr = 1'b0; // x0 is never written
        end
    end

    // alignment flags
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_wr    <= 1'b0;
            s1_redir <= 1'b0;
            s2_wr    <= 1'b0;
            s2_redir <= 1'b0;
        end else begin
            s1_wr    <= dec_wr;
            s1_redir <= dec_redir;
            s2_wr    <= s1_wr;
            s2_redir <= s1_redir;
        end
    end

    // alignment payload
    always_ff @(posedge clk_i) begin
        s1_cls    <= issue.op_class;
        s1_rd     <= issue.rd_addr;
        s1_data   <= dec_data;
        s1_target <= br_target_i;
        s2_cls    <= s1_cls;
        s2_rd     <= s1_rd;
        s2_data   <= s1_data;
        s2_target <= s1_target;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            wb_valid_o <= s2_wr;
            redirect_o <= s2_redir;
        end
    end

    // multiplier output lines up with stage two
    always_ff @(posedge clk_i) begin
        wb_addr_o     <= s2_rd;
        wb_data_o     <= (s2_cls == CLS_MUL) ? mul_result_i : s2_data;
        redirect_pc_o <= s2_target;
    end

endmodule

/* design/exec_top.sv */
// execute stage top level, plain issue ports in and write-back plus redirect out after three cycles
`timescale 1ns/1ps

module exec_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                issue_valid_i,
    input  exec_pkg::op_class_e op_class_i,
    input  exec_pkg::op_code_t  op_code_i,
    input  exec_pkg::word_t     rs1_val_i,
    input  exec_pkg::word_t     rs2_val_i,
    input  exec_pkg::word_t     imm_i,
    input  exec_pkg::word_t     pc_i,
    input  exec_pkg::reg_addr_t rd_addr_i,
    output logic                wb_valid_o,
    output exec_pkg::reg_addr_t wb_addr_o,
    output exec_pkg::word_t     wb_data_o,
    output logic                redirect_o,
    output exec_pkg::word_t     redirect_pc_o
);
    import exec_pkg::*;

    word_t   alu_result;
    logic    br_taken;
    word_t   br_target;
    word_t   br_link;
    logic    mul_start;
    mul_op_e mul_op;
    word_t   mul_result;

    exec_issue_if issue_if ();

    assign issue_if.valid    = issue_valid_i;
    assign issue_if.op_class = op_class_i;
    assign issue_if.op_code  = op_code_i;
    assign issue_if.rs1_val  = rs1_val_i;
    assign issue_if.rs2_val  = rs2_val_i;
    assign issue_if.imm      = imm_i;
    assign issue_if.pc       = pc_i;
    assign issue_if.rd_addr  = rd_addr_i;

    exec_alu alu_i (
        .issue    (issue_if.unit),
        .result_o (alu_result)
    );

    exec_branch branch_i (
        .issue    (issue_if.unit),
        .taken_o  (br_taken),
        .target_o (br_target),
        .link_o   (br_link)
    );

    exec_mul mul_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .op_i     (mul_op),
        .issue    (issue_if.unit),
        .result_o (mul_result)
    );

    exec_ctrl ctrl_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue         (issue_if.ctrl),
        .alu_result_i  (alu_result),
        .br_taken_i    (br_taken),
        .br_target_i   (br_target),
        .br_link_i     (br_link),
        .mul_result_i  (mul_result),
        .mul_start_o   (mul_start),
        .mul_op_o      (mul_op),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* tb/exec_tb.sv */
// self-checking testbench of the execute stage, run with the project file list and exec_tb as top
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_tb;
    import exec_pkg::*;

    localparam word_t SIGN_BIT = word_t'(1) << (`EXEC_XLEN - 1);

    typedef struct packed {
        logic        wb;
        reg_addr_t   rd;
        word_t       data;
        logic        redir;
        word_t       pc;
        logic [31:0] due;    // checker edge that sees the result
    } exp_t;

    logic        clk_i;
    logic        rst_i;
    logic        issue_valid;
    op_class_e   op_class;
    op_code_t    op_code;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       imm;
    word_t       pc;
    reg_addr_t   rd_addr;
    logic        wb_valid_o;
    reg_addr_t   wb_addr_o;
    word_t       wb_data_o;
    logic        redirect_o;
    word_t       redirect_pc_o;

    exp_t        exp_q[$];
    string       name_q[$];
    exp_t        exp_cur;
    string       name_cur;
    logic [31:0] cyc = '0;   // rising edges seen so far
    int          errors = 0;
    int          checks = 0;
    int          timeouts = 0;
    word_t       corners[6] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff,
                                32'h0000_0025};

    exec_top dut_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid),
        .op_class_i    (op_class),
        .op_code_i     (op_code),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .imm_i         (imm),
        .pc_i          (pc),
        .rd_addr_i     (rd_addr),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        logic [2*`EXEC_XLEN-1:0] ext;
        ext = {{`EXEC_XLEN{a[`EXEC_XLEN-1]}}, a}; // sign copies shift in from the top
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + word_t'(1);
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return word_t'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
            ALU_SLTU: return word_t'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'(ext >> b[4:0]);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic word_t mul_model(mul_op_e op, word_t a, word_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = (op == MUL_MULH || op == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'h0, a};
        eb = (op == MUL_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        p  = ea * eb; // modulo 2^64 product is exact for both signs
        return (op == MUL_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic exp_t result_model(op_class_e cls, op_code_t code, word_t a, word_t b,
                                          word_t im, word_t pcv, reg_addr_t rd);
        exp_t e;
        e    = '0;
        e.rd = rd;
        case (cls)
            CLS_ALU: begin
                e.wb   = 1'b1;
                e.data = alu_model(alu_op_e'(code), a, b);
            end
            CLS_MUL: begin
                e.wb   = 1'b1;
                e.data = mul_model(mul_op_e'(code), a, b);
            end
            CLS_BRANCH: begin
                case (br_op_e'(code))
                    BR_BEQ:  e.redir = (a == b);
                    BR_BNE:  e.redir = (a != b);
                    BR_BLT:  e.redir = ((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
                    BR_BGE:  e.redir = ((a ^ SIGN_BIT) >= (b ^ SIGN_BIT));
                    BR_BLTU: e.redir = (a < b);
                    BR_BGEU: e.redir = (a >= b);
                    default: begin
                        e.redir = 1'b1;       // jal and jalr
                        e.wb    = 1'b1;
                        e.data  = pcv + 32'd4;
                    end
                endcase
                e.pc = (code == BR_JALR) ? ((a + im) & ~32'h1) : (pcv + im);
            end
            default: e = '0; // invalid class does nothing
        endcase
        if (rd == '0) begin
            e.wb = 1'b0;
        end
        return e;
    endfunction

    task automatic report_error(string test, string field, word_t expected, word_t actual);
        errors++;
        $display("[ERROR] %s %s expected %h actual %h", test, field, expected, actual);
    endtask

    task automatic issue_op(string test, op_class_e cls, op_code_t code, word_t a, word_t b,
                            word_t im, word_t pcv, reg_addr_t rd);
        exp_t e;
        @(negedge clk_i);
        issue_valid = 1'b1;
        op_class    = cls;
        op_code     = code;
        rs1_val     = a;
        rs2_val     = b;
        imm         = im;
        pc          = pcv;
        rd_addr     = rd;
        e     = result_model(cls, code, a, b, im, pcv, rd);
        e.due = cyc + 32'd4; // output registers load two edges after the issue edge
        exp_q.push_back(e);
        name_q.push_back(test);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk_i);
            issue_valid = 1'b0;
        end
    endtask

    // outputs are read before this edge updates them
    always @(posedge clk_i) begin
        cyc = cyc + 32'd1;
        if (!rst_i) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                exp_cur  = exp_q.pop_front();
                name_cur = name_q.pop_front();
                checks++;
                assert (wb_valid_o === exp_cur.wb)
                    else report_error(name_cur, "wb_valid", exp_cur.wb, wb_valid_o);
                if (exp_cur.wb) begin
                    assert (wb_addr_o === exp_cur.rd)
                        else report_error(name_cur, "wb_addr", exp_cur.rd, wb_addr_o);
                    assert (wb_data_o === exp_cur.data)
                        else report_error(name_cur, "wb_data", exp_cur.data, wb_data_o);
                end
                assert (redirect_o === exp_cur.redir)
                    else report_error(name_cur, "redirect", exp_cur.redir, redirect_o);
                if (exp_cur.redir) begin
                    assert (redirect_pc_o === exp_cur.pc)
                        else report_error(name_cur, "redirect_pc", exp_cur.pc, redirect_pc_o);
                end
            end else begin
                assert (wb_valid_o === 1'b0) else report_error("idle", "wb_valid", 0, wb_valid_o);
                assert (redirect_o === 1'b0) else report_error("idle", "redirect", 0, redirect_o);
            end
        end
    end

    initial begin
        int        wait_cnt;
        op_class_e cls;
        void'($urandom(32'h9d228193));
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        issue_valid = 1'b0;
        op_class    = CLS_NONE;
        op_code     = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        imm         = '0;
        pc          = '0;
        rd_addr     = '0;
        repeat (16) @(negedge clk_i);
        rst_i = 1'b0;
        idle(8); // quiet outputs with nothing issued

        for (int op = 0; op < 10; op++) begin
            for (int j = 0; j < 6; j++) begin
                for (int k = 0; k < 6; k++) begin
                    issue_op("alu", CLS_ALU, op_code_t'(op), corners[j], corners[k], '0, '0,
                             reg_addr_t'($urandom_range(1, 31)));
                end
            end
            issue_op("alu", CLS_ALU, op_code_t'(op), $urandom, $urandom, '0, '0, 5'd3);
        end
        idle(2);

        for (int op = 0; op < 4; op++) begin
            for (int j = 0; j < 6; j++) begin
                for (int k = 0; k < 6; k++) begin
                    issue_op("mul", CLS_MUL, op_code_t'(op), corners[j], corners[k], '0, '0,
                             reg_addr_t'($urandom_range(1, 31)));
                end
            end
            issue_op("mul", CLS_MUL, op_code_t'(op), $urandom, $urandom, '0, '0, 5'd9);
        end
        idle(2);

        for (int op = 0; op < 8; op++) begin
            for (int j = 0; j < 6; j++) begin
                for (int k = 0; k < 6; k++) begin
                    issue_op("branch", CLS_BRANCH, op_code_t'(op), corners[j], corners[k],
                             $urandom & ~32'h1, $urandom & ~32'h3,
                             reg_addr_t'($urandom_range(1, 31)));
                end
            end
        end
        idle(2);

        issue_op("rd0", CLS_ALU, op_code_t'(ALU_ADD), 32'd5, 32'd6, '0, '0, '0);
        issue_op("rd0", CLS_MUL, op_code_t'(MUL_MUL), 32'd5, 32'd6, '0, '0, '0);
        issue_op("rd0", CLS_BRANCH, op_code_t'(BR_JAL), '0, '0, 32'h10, 32'h100, '0);
        issue_op("none", CLS_NONE, op_code_t'(ALU_ADD), 32'd1, 32'd2, '0, '0, 5'd7);
        idle(3);

        // mixed stream, one op per cycle
        for (int i = 0; i < 300; i++) begin
            cls = op_class_e'($urandom_range(0, 3));
            issue_op("stream", cls,
                     op_code_t'((cls == CLS_ALU) ? $urandom_range(0, 9) :
                                (cls == CLS_MUL) ? $urandom_range(0, 3) : $urandom_range(0, 7)),
                     $urandom, $urandom, $urandom, $urandom & ~32'h3,
                     reg_addr_t'($urandom_range(0, 31)));
        end
        idle(1);

        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < 100) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d results never appeared on the outputs", exp_q.size());
            timeouts++;
        end
        $display("checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/exec_pkg.sv
design/exec_issue_if.sv
design/exec_alu.sv
design/exec_branch.sv
design/exec_mul.sv
design/exec_ctrl.sv
design/exec_top.sv
tb/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/exec_pkg.sv
      - design/exec_issue_if.sv
      - design/exec_alu.sv
      - design/exec_branch.sv
      - design/exec_mul.sv
      - design/exec_ctrl.sv
      - design/exec_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/exec_tb.sv
